// File: Makefile
# Verilator build and run of the core test monitor testbench

VERILATOR ?= verilator
TOP       ?= coreTestMon_tb
LOG       ?= sim.log
SEED      ?= 1
BUILD     ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+seed+$(SEED) +verilator+error+limit+100

SIM_BIN := $(BUILD)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	-$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation gave no result, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: filelist.f
src/monRegPkg.sv
src/coreTracePkg.sv
src/monRegFile.sv
src/pcProgressMon.sv
src/coreResetCtl.sv
src/coreTestMon.sv
sim/coreTestMon_chk.sv
sim/coreTestMon_tb.sv

// File: sim/coreTestMon_chk.sv
// Bound assertions on the AXI4-Lite handshake and the sleep reset of the core test monitor
`timescale 1ns/1ps

module coreTestMon_chk #(
  parameter int SleepDelay = 20
) (
  input logic                  dvtFlags,
  input logic                  pcFail,
  input logic                  awready,
  input logic                  wready,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready,
  input logic                  coreReset,
  input logic                  coreResetReq,
  input coreTracePkg::verdictT verdict
);
  import coreTracePkg::*;

  int failCount = 0;  // Assertion failures so far

  // ------------------------------
  // AXI4-Lite handshake
  // ------------------------------
  bHold: assert property (@(posedge dvtFlags) disable iff (pcFail)
    bvalid && !bready |=> bvalid)
    else begin
      failCount++;
      $error("bvalid dropped before bready");
    end

  rHold: assert property (@(posedge dvtFlags) disable iff (pcFail)
    rvalid && !rready |=> rvalid)
    else begin
      failCount++;
      $error("rvalid dropped before rready");
    end

  readyPair: assert property (@(posedge dvtFlags) disable iff (pcFail)
    $rose(awready) || $rose(wready) |-> awready && wready)
    else begin
      failCount++;
      $error("awready and wready rose apart");
    end

  // No early sleep reset unless software asked for it
  sleepWait: assert property (@(posedge dvtFlags) disable iff (pcFail)
    $rose(coreReset) && !$past(coreResetReq) |-> ($past(verdict, SleepDelay) != verdictNone))
    else begin
      failCount++;
      $error("coreReset rose before the sleep delay ran out");
    end

endmodule

bind coreTestMon coreTestMon_chk #(.SleepDelay(SleepDelay)) chk_i (
  .dvtFlags     (dvtFlags),
  .pcFail       (pcFail),
  .awready      (awready),
  .wready       (wready),
  .bvalid       (bvalid),
  .bready       (bready),
  .rvalid       (rvalid),
  .rready       (rready),
  .coreReset    (coreReset),
  .coreResetReq (coreResetReq),
  .verdict      (verdict)
);

// File: sim/coreTestMon_tb.sv
// Table driven testbench for the core test monitor over AXI4-Lite and the PC trace
`timescale 1ns/1ps

module coreTestMon_tb;
  import monRegPkg::*;
  import coreTracePkg::*;

  localparam int SleepCycles = 20;
  localparam int StuckInit   = 500;
  localparam int RowSlack    = 50;  // Watchdog allowance per row

  typedef logic [AxiStrbWidth-1:0] strbT;
  typedef enum int {opReset, opWrite, opRead, opPcSame, opPcRand, opIdle, opLevel} opT;

  // Table entries use only the low word
  localparam regDataT PcPass   = 32'h8000_1000;
  localparam regDataT PcFail   = 32'h8000_2000;
  localparam regDataT PcFinish = 32'h8000_3000;
  localparam regDataT PcToHost = 32'h8000_4000;
  localparam regDataT PcHang   = 32'h8000_5000;
  localparam regDataT PcLoop   = 32'h9000_0040;  // Outside the table

  logic    dvtFlags;
  logic    pcFail;
  regAddrT awaddr;
  logic    awvalid;
  logic    awready;
  regDataT wdata;
  strbT    wstrb;
  logic    wvalid;
  logic    wready;
  axiRespT bresp;
  logic    bvalid;
  logic    bready;
  regAddrT araddr;
  logic    arvalid;
  logic    arready;
  regDataT rdata;
  axiRespT rresp;
  logic    rvalid;
  logic    rready;
  pcT      curPc;
  logic    curPcValid;
  logic    tileReset;
  logic    coreReset;

  // Stimulus table
  opT      rowOp [$];
  regAddrT rowAddr [$];
  regDataT rowData [$];
  strbT    rowStrb [$];
  regDataT rowExp [$];
  axiRespT rowResp [$];
  int      rowCycles [$];

  int     errors = 0;
  int     checks = 0;
  int     watchdogCycles = 0;
  bit     tableReady = 1'b0;
  integer seed = 32'hf5e1_2698;

  coreTestMon #(.SleepDelay(SleepCycles), .StuckLimitInit(StuckInit)) dut_i (.*);

  initial begin
    dvtFlags = 1'b0;
    forever #5 dvtFlags = ~dvtFlags;
  end

  function automatic regDataT bitOf(int pos);
    return regDataT'(1) << pos;
  endfunction

  function automatic void pushRow(opT op, regAddrT addr, regDataT data, strbT strb,
                                  regDataT expVal, axiRespT resp, int cycles);
    rowOp.push_back(op);
    rowAddr.push_back(addr);
    rowData.push_back(data);
    rowStrb.push_back(strb);
    rowExp.push_back(expVal);
    rowResp.push_back(resp);
    rowCycles.push_back(cycles);
  endfunction

  function automatic void wrRow(regAddrT addr, regDataT data, strbT strb, axiRespT resp);
    pushRow(opWrite, addr, data, strb, '0, resp, 4);
  endfunction

  function automatic void rdRow(regAddrT addr, regDataT expVal, axiRespT resp);
    pushRow(opRead, addr, '0, '0, expVal, resp, 4);
  endfunction

  function automatic void pcRow(opT op, regDataT pc, int count);
    pushRow(op, '0, pc, '0, '0, respOkay, count + 1);
  endfunction

  function automatic void idleRow(int count);
    pushRow(opIdle, '0, '0, '0, '0, respOkay, count);
  endfunction

  // Expected levels of tileReset and coreReset
  function automatic void levelRow(logic tileExp, logic coreExp);
    pushRow(opLevel, '0, '0, '0, regDataT'({tileExp, coreExp}), respOkay, 0);
  endfunction

  function automatic void resetRow();
    pushRow(opReset, '0, '0, '0, '0, respOkay, 3);
  endfunction

  function automatic void loadTable();
    wrRow(regAddrT'(RegTableBase + 8 * EntryTestPass), PcPass, 4'hF, respOkay);
    wrRow(regAddrT'(RegTableBase + 8 * EntryTestFail), PcFail, 4'hF, respOkay);
    wrRow(regAddrT'(RegTableBase + 8 * EntryFinish), PcFinish, 4'hF, respOkay);
    wrRow(regAddrT'(RegTableBase + 8 * EntryToHost), PcToHost, 4'hF, respOkay);
    wrRow(regAddrT'(RegTableBase + 8 * EntryHang), PcHang, 4'hF, respOkay);
  endfunction

  function automatic void buildTable();
    regDataT ctrlRun;
    ctrlRun = bitOf(CtrlTableValid);  // Table valid and tile released
    // ------------------------------
    // Reset values and register access
    // ------------------------------
    resetRow();
    rdRow(RegCtrl, bitOf(CtrlTileReset), respOkay);
    rdRow(RegStuckLimit, regDataT'(StuckInit), respOkay);
    rdRow(RegStatus, bitOf(StatTileReset), respOkay);
    levelRow(1'b1, 1'b0);
    wrRow(8'h10, 32'h1122_3344, 4'hF, respOkay);
    wrRow(8'h10, 32'hAABB_CCDD, 4'b0101, respOkay);
    rdRow(8'h10, 32'h11BB_33DD, respOkay);
    wrRow(8'h14, 32'hCAFE_F00D, 4'b1000, respOkay);
    rdRow(8'h14, 32'hCA00_0000, respOkay);
    wrRow(RegStuckLimit, 32'h0000_1234, 4'b0001, respOkay);  // 0x1F4 with low byte 0x34
    rdRow(RegStuckLimit, 32'h0000_0134, respOkay);
    wrRow(RegStatus, 32'hFFFF_FFFF, 4'hF, respOkay);
    rdRow(RegStatus, bitOf(StatTileReset), respOkay);
    wrRow(8'h38, 32'h5A5A_5A5A, 4'hF, respSlvErr);
    rdRow(8'h38, '0, respSlvErr);
    // ------------------------------
    // Pass, then sleep
    // ------------------------------
    resetRow();
    loadTable();
    wrRow(RegCtrl, ctrlRun, 4'hF, respOkay);
    pcRow(opPcRand, '0, 30);
    pcRow(opPcSame, PcPass, 1);
    idleRow(17);  // 18 cycles after the pass PC
    levelRow(1'b0, 1'b0);
    idleRow(4);
    levelRow(1'b0, 1'b1);
    rdRow(RegStatus, bitOf(StatPass) | bitOf(StatCoreReset), respOkay);
    // To-host only counts with check-to-host set
    resetRow();
    loadTable();
    wrRow(RegCtrl, ctrlRun, 4'hF, respOkay);
    pcRow(opPcSame, PcToHost, 1);
    rdRow(RegStatus, '0, respOkay);
    wrRow(RegCheckToHost, 32'h1, 4'hF, respOkay);
    pcRow(opPcSame, PcToHost, 1);
    rdRow(RegStatus, bitOf(StatPass), respOkay);
    // ------------------------------
    // Fail paths and stuck detection
    // ------------------------------
    resetRow();
    loadTable();
    wrRow(RegCtrl, ctrlRun, 4'hF, respOkay);
    pcRow(opPcSame, PcHang, 1);
    rdRow(RegStatus, bitOf(StatFail), respOkay);
    resetRow();
    pcRow(opPcRand, '0, 3);  // Table never marked valid
    rdRow(RegStatus, bitOf(StatFail) | bitOf(StatTileReset), respOkay);
    resetRow();
    loadTable();
    wrRow(RegStuckLimit, 32'd8, 4'hF, respOkay);
    wrRow(RegCtrl, ctrlRun, 4'hF, respOkay);
    pcRow(opPcSame, PcLoop, 10);
    rdRow(RegStatus, bitOf(StatFail) | bitOf(StatStuck), respOkay);
    resetRow();
    loadTable();
    wrRow(RegStuckLimit, 32'd8, 4'hF, respOkay);
    wrRow(RegCtrl, ctrlRun | bitOf(CtrlDisableStuck), 4'hF, respOkay);
    pcRow(opPcSame, PcLoop, 10);
    rdRow(RegStatus, '0, respOkay);
    pcRow(opPcSame, PcPass, 1);
    idleRow(25);
    levelRow(1'b0, 1'b0);  // No sleep with stuck checking off
    rdRow(RegStatus, bitOf(StatPass), respOkay);
    // Force-fail overrides a pass
    resetRow();
    loadTable();
    wrRow(RegCtrl, ctrlRun, 4'hF, respOkay);
    pcRow(opPcSame, PcFinish, 1);
    rdRow(RegStatus, bitOf(StatPass), respOkay);
    wrRow(RegCtrl, ctrlRun | bitOf(CtrlForceFail), 4'hF, respOkay);
    rdRow(RegStatus, bitOf(StatFail), respOkay);
    rdRow(RegCtrl, ctrlRun, respOkay);
  endfunction

  task automatic checkWord(string what, regDataT got, regDataT expVal);
    checks++;
    if (got !== expVal) begin
      errors++;
      $display("** Error at %0t: %s is 0x%h, expected 0x%h", $time, what, got, expVal);
    end
  endtask

  task automatic checkResp(string what, axiRespT got, axiRespT expVal);
    checks++;
    if (got !== expVal) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, expVal);
    end
  endtask

  task automatic checkLevel(string what, logic got, logic expVal);
    checks++;
    if (got !== expVal) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, expVal);
    end
  endtask

  task automatic applyReset();
    @(posedge dvtFlags);
    #1;
    pcFail     = 1'b1;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    arvalid    = 1'b0;
    curPcValid = 1'b0;
    repeat (3) @(posedge dvtFlags);
    #1;
    pcFail = 1'b0;
  endtask

  task automatic writeReg(input regAddrT addr, input regDataT data, input strbT strb,
                          output axiRespT resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(posedge dvtFlags);
      #1;
    end while (!(awready && wready));
    @(posedge dvtFlags);  // Handshake edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    checkLevel("bvalid", bvalid, 1'b1);
    @(posedge dvtFlags);  // Response held back one cycle
    #1;
    checkLevel("bvalid", bvalid, 1'b1);
    resp   = bresp;
    bready = 1'b1;
    @(posedge dvtFlags);
    #1;
    bready = 1'b0;
  endtask

  task automatic readReg(input regAddrT addr, output regDataT data, output axiRespT resp);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(posedge dvtFlags);
      #1;
    end while (!arready);
    @(posedge dvtFlags);
    #1;
    arvalid = 1'b0;
    checkLevel("rvalid", rvalid, 1'b1);
    @(posedge dvtFlags);  // Read data held back one cycle
    #1;
    checkLevel("rvalid", rvalid, 1'b1);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(posedge dvtFlags);
    #1;
    rready = 1'b0;
  endtask

  // Random PCs stay in 0x9xxx_xxxx where no table entry lies
  task automatic feedPcs(input regDataT pc, input bit randomPc, input int count);
    regDataT low;
    for (int i = 0; i < count; i++) begin
      if (randomPc) begin
        low   = regDataT'($random(seed)) & 32'h0FFF_FFFC;
        curPc = {32'h0, 32'h9000_0000 | low};
      end else begin
        curPc = {32'h0, pc};
      end
      curPcValid = 1'b1;
      @(posedge dvtFlags);
      #1;
    end
    curPcValid = 1'b0;
  endtask

  task automatic waitCycles(input int count);
    repeat (count) begin
      @(posedge dvtFlags);
      #1;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    regDataT data;
    axiRespT resp;
    pcFail     = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    curPc      = '0;
    curPcValid = 1'b0;
    buildTable();
    foreach (rowCycles[r]) watchdogCycles += rowCycles[r] + RowSlack;
    tableReady = 1'b1;
    for (int r = 0; r < rowOp.size(); r++) begin
      case (rowOp[r])
        opReset: applyReset();
        opWrite: begin
          writeReg(rowAddr[r], rowData[r], rowStrb[r], resp);
          checkResp($sformatf("bresp of 0x%h", rowAddr[r]), resp, rowResp[r]);
        end
        opRead: begin
          readReg(rowAddr[r], data, resp);
          checkWord($sformatf("rdata of 0x%h", rowAddr[r]), data, rowExp[r]);
          checkResp($sformatf("rresp of 0x%h", rowAddr[r]), resp, rowResp[r]);
        end
        opPcSame: feedPcs(rowData[r], 1'b0, rowCycles[r] - 1);
        opPcRand: feedPcs('0, 1'b1, rowCycles[r] - 1);
        opIdle:   waitCycles(rowCycles[r]);
        default: begin
          checkLevel("tileReset", tileReset, rowExp[r][1]);
          checkLevel("coreReset", coreReset, rowExp[r][0]);
        end
      endcase
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.chk_i.failCount);
    if (errors == 0 && dut_i.chk_i.failCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (tableReady);
    repeat (watchdogCycles) @(posedge dvtFlags);
    $display("Watchdog expired after %0d cycles, the sequence did not finish", watchdogCycles);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.chk_i.failCount);
    $display("Something failed");
    $finish;
  end

endmodule

// File: src/coreResetCtl.sv
// Tile and core reset driver with a delayed sleep reset after the verdict
`timescale 1ns/1ps

module coreResetCtl #(
  parameter int SleepDelay = 20
) (
  input  logic                  dvtFlags,
  input  logic                  pcFail,
  input  logic                  tileResetReq,
  input  logic                  coreResetReq,
  input  logic                  disableStuck,
  input  coreTracePkg::verdictT verdict,
  output logic                  tileReset,
  output logic                  coreReset
);
  import coreTracePkg::*;

  localparam int CntWidth = $clog2(SleepDelay + 1);

  logic [CntWidth-1:0] sleepCnt;
  logic                coreResetReg;  // Software request, registered
  logic                asleep;        // Held until the next reset
  logic                sleepDone;

  assign sleepDone = (sleepCnt == CntWidth'(SleepDelay - 1));

  // ------------------------------
  // Requested resets
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileReset    <= 1'b1;
      coreResetReg <= 1'b0;
    end else begin
      tileReset    <= tileResetReq;
      coreResetReg <= coreResetReq;
    end
  end

  // ------------------------------
  // Sleep after verdict
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      sleepCnt <= '0;
      asleep   <= 1'b0;
    end else if ((verdict != verdictNone) && !disableStuck && !asleep) begin
      if (sleepDone) begin
        asleep <= 1'b1;
      end else begin
        sleepCnt <= sleepCnt + 1'b1;
      end
    end
  end

  assign coreReset = coreResetReg || asleep;

endmodule

// File: src/coreTestMon.sv
// Per-core test monitor top with register block, PC monitor and reset control
`timescale 1ns/1ps

module coreTestMon #(
  parameter int SleepDelay     = 20,
  parameter int StuckLimitInit = 500
) (
  input  logic                               dvtFlags,
  input  logic                               pcFail,
  // AXI4-Lite slave
  input  monRegPkg::regAddrT                 awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  monRegPkg::regDataT                 wdata,
  input  logic [monRegPkg::AxiStrbWidth-1:0] wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output monRegPkg::axiRespT                 bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  monRegPkg::regAddrT                 araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output monRegPkg::regDataT                 rdata,
  output monRegPkg::axiRespT                 rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Core trace
  input  coreTracePkg::pcT                   curPc,
  input  logic                               curPcValid,
  // Reset lines to the tile
  output logic                               tileReset,
  output logic                               coreReset
);
  import coreTracePkg::*;

  logic     tileResetReq;
  logic     coreResetReq;
  logic     disableStuck;
  logic     checkToHost;
  logic     tableValid;
  logic     forceFailPulse;
  logic     stuck;
  stuckCntT stuckLimit;
  pcT       passFailAddr [PassFailEntries];
  verdictT  verdict;

  // All connections share names with the top level
  monRegFile #(.StuckLimitInit(StuckLimitInit)) regFile_i (.*);

  pcProgressMon progressMon_i (.*);

  coreResetCtl #(.SleepDelay(SleepDelay)) resetCtl_i (.*);

endmodule

// File: src/coreTracePkg.sv
// PC trace types, verdict encoding and pass/fail table roles

package coreTracePkg;

  // ------------------------------
  // Program counter
  // ------------------------------
  localparam int PcWidth = 64;

  typedef logic [PcWidth-1:0] pcT;

  // Test outcome, sticky once set
  typedef enum logic [1:0] {
    verdictNone = 2'd0,
    verdictPass = 2'd1,
    verdictFail = 2'd2
  } verdictT;

  // ------------------------------
  // Pass/fail address table
  // ------------------------------
  localparam int PassFailEntries = 5;

  localparam int EntryTestPass = 0;  // Pass
  localparam int EntryTestFail = 1;  // Fail
  localparam int EntryFinish   = 2;  // Pass
  localparam int EntryToHost   = 3;  // Pass only with check-to-host set
  localparam int EntryHang     = 4;  // Fail

  // Repeat count of the same PC
  localparam int StuckCntWidth = 32;

  typedef logic [StuckCntWidth-1:0] stuckCntT;

endpackage

// File: src/monRegFile.sv
// AXI4-Lite register block with control, status, stuck limit and pass/fail table
`timescale 1ns/1ps

module monRegFile #(
  parameter int StuckLimitInit = 500
) (
  input  logic                               dvtFlags,
  input  logic                               pcFail,
  // AXI4-Lite slave
  input  monRegPkg::regAddrT                 awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  monRegPkg::regDataT                 wdata,
  input  logic [monRegPkg::AxiStrbWidth-1:0] wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output monRegPkg::axiRespT                 bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  monRegPkg::regAddrT                 araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output monRegPkg::regDataT                 rdata,
  output monRegPkg::axiRespT                 rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Status sources
  input  coreTracePkg::verdictT              verdict,
  input  logic                               stuck,
  input  logic                               coreReset,
  // Control outputs
  output logic                               tileResetReq,
  output logic                               coreResetReq,
  output logic                               disableStuck,
  output logic                               checkToHost,
  output logic                               tableValid,
  output logic                               forceFailPulse,
  output coreTracePkg::stuckCntT             stuckLimit,
  output coreTracePkg::pcT                   passFailAddr [coreTracePkg::PassFailEntries]
);
  import monRegPkg::*;
  import coreTracePkg::*;

  localparam int TableWords  = 2 * PassFailEntries;
  localparam int TblIdxWidth = $clog2(TableWords);

  regDataT tableWord [TableWords];  // Low/high word pairs
  regDataT ctrlView;
  regDataT statusView;
  regDataT ctrlWrVal;
  regDataT hostWrVal;
  regDataT rdWord;
  regAddrT wrAddr;
  regAddrT rdAddr;
  logic    wrAccept;
  logic    wrFire;
  logic    rdFire;

  function automatic regDataT mergeBytes(regDataT oldVal, regDataT newVal,
                                         logic [AxiStrbWidth-1:0] strb);
    regDataT merged;
    merged = oldVal;
    for (int b = 0; b < AxiStrbWidth; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = newVal[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic inTable(regAddrT a);
    return (a >= RegTableBase) && (a <= RegTableEnd);
  endfunction

  function automatic logic [TblIdxWidth-1:0] tableIdx(regAddrT a);
    regAddrT offset;
    offset = a - RegTableBase;
    return offset[2 +: TblIdxWidth];
  endfunction

  function automatic logic isMapped(regAddrT a);
    return (a == RegCtrl) || (a == RegStatus) || (a == RegStuckLimit) ||
           (a == RegCheckToHost) || inTable(a);
  endfunction

  // Word aligned decode, byte offset ignored
  assign wrAddr   = {awaddr[AxiAddrWidth-1:2], 2'b00};
  assign rdAddr   = {araddr[AxiAddrWidth-1:2], 2'b00};
  assign wrAccept = !awready && awvalid && wvalid && !bvalid;
  assign wrFire   = awready && awvalid && wready && wvalid;
  assign rdFire   = arready && arvalid;

  always_comb begin
    ctrlView = '0;
    ctrlView[CtrlTileReset]    = tileResetReq;
    ctrlView[CtrlCoreReset]    = coreResetReq;
    ctrlView[CtrlDisableStuck] = disableStuck;
    ctrlView[CtrlTableValid]   = tableValid;  // Force-fail always reads 0
  end

  always_comb begin
    statusView = '0;
    statusView[StatPass]      = (verdict == verdictPass);
    statusView[StatFail]      = (verdict == verdictFail);
    statusView[StatStuck]     = stuck;
    statusView[StatTileReset] = tileResetReq;
    statusView[StatCoreReset] = coreReset;
  end

  assign ctrlWrVal = mergeBytes(ctrlView, wdata, wstrb);
  assign hostWrVal = mergeBytes(regDataT'(checkToHost), wdata, wstrb);

  for (genvar e = 0; e < PassFailEntries; e++) begin : gEntry
    assign passFailAddr[e] = {tableWord[2*e+1], tableWord[2*e]};
  end

  // ------------------------------
  // Handshake state
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= wrAccept;  // One cycle pulse, both channels together
      wready  <= wrAccept;
      arready <= !arready && arvalid && !rvalid;
      if (wrFire) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (rdFire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge dvtFlags) begin
    if (wrFire) begin
      bresp <= isMapped(wrAddr) ? respOkay : respSlvErr;
    end
    if (rdFire) begin
      rdata <= rdWord;
      rresp <= isMapped(rdAddr) ? respOkay : respSlvErr;
    end
  end

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileResetReq   <= CtrlResetValue[CtrlTileReset];
      coreResetReq   <= CtrlResetValue[CtrlCoreReset];
      disableStuck   <= CtrlResetValue[CtrlDisableStuck];
      tableValid     <= CtrlResetValue[CtrlTableValid];
      forceFailPulse <= 1'b0;
      checkToHost    <= 1'b0;
      stuckLimit     <= stuckCntT'(StuckLimitInit);
      for (int i = 0; i < TableWords; i++) begin
        tableWord[i] <= '0;
      end
    end else begin
      forceFailPulse <= 1'b0;
      if (wrFire) begin
        if (wrAddr == RegCtrl) begin
          tileResetReq   <= ctrlWrVal[CtrlTileReset];
          coreResetReq   <= ctrlWrVal[CtrlCoreReset];
          disableStuck   <= ctrlWrVal[CtrlDisableStuck];
          tableValid     <= ctrlWrVal[CtrlTableValid];
          forceFailPulse <= ctrlWrVal[CtrlForceFail];
        end else if (wrAddr == RegStuckLimit) begin
          stuckLimit <= mergeBytes(stuckLimit, wdata, wstrb);
        end else if (wrAddr == RegCheckToHost) begin
          checkToHost <= hostWrVal[0];
        end else if (inTable(wrAddr)) begin
          tableWord[tableIdx(wrAddr)] <= mergeBytes(tableWord[tableIdx(wrAddr)], wdata, wstrb);
        end
        // STATUS and unmapped writes fall through
      end
    end
  end

  // Read mux, unmapped returns zero
  always_comb begin
    rdWord = '0;
    case (rdAddr)
      RegCtrl:        rdWord = ctrlView;
      RegStatus:      rdWord = statusView;
      RegStuckLimit:  rdWord = stuckLimit;
      RegCheckToHost: rdWord = regDataT'(checkToHost);
      default: begin
        if (inTable(rdAddr)) begin
          rdWord = tableWord[tableIdx(rdAddr)];
        end
      end
    endcase
  end

endmodule

// File: src/monRegPkg.sv
// Register map, bit positions and AXI4-Lite types of the core test monitor

package monRegPkg;

  // ------------------------------
  // Bus widths and types
  // ------------------------------
  localparam int AxiAddrWidth = 8;
  localparam int AxiDataWidth = 32;
  localparam int AxiStrbWidth = AxiDataWidth / 8;

  typedef logic [AxiAddrWidth-1:0] regAddrT;
  typedef logic [AxiDataWidth-1:0] regDataT;

  typedef enum logic [1:0] {
    respOkay   = 2'b00,
    respSlvErr = 2'b10
  } axiRespT;

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam regAddrT RegCtrl        = 8'h00;
  localparam regAddrT RegStatus      = 8'h04;
  localparam regAddrT RegStuckLimit  = 8'h08;
  localparam regAddrT RegCheckToHost = 8'h0C;
  localparam regAddrT RegTableBase   = 8'h10;  // Entry i low word at base + 8i
  localparam regAddrT RegTableEnd    = 8'h37;  // Last byte of the pass/fail table

  // CTRL bits
  localparam int CtrlTileReset    = 0;
  localparam int CtrlCoreReset    = 1;
  localparam int CtrlDisableStuck = 2;
  localparam int CtrlForceFail    = 3;  // Self clearing
  localparam int CtrlTableValid   = 4;

  // STATUS bits
  localparam int StatPass       = 0;
  localparam int StatFail       = 1;
  localparam int StatStuck      = 2;
  localparam int StatTileReset  = 3;
  localparam int StatCoreReset  = 4;

  // Tile held in reset until software releases it
  localparam regDataT CtrlResetValue = regDataT'(1) << CtrlTileReset;

endpackage

// File: src/pcProgressMon.sv
// PC trace monitor judging pass, fail and stuck from the retired PC stream
`timescale 1ns/1ps

module pcProgressMon (
  input  logic                   dvtFlags,
  input  logic                   pcFail,
  input  coreTracePkg::pcT       curPc,
  input  logic                   curPcValid,
  input  logic                   coreReset,
  input  logic                   disableStuck,
  input  logic                   checkToHost,
  input  logic                   tableValid,
  input  logic                   forceFailPulse,
  input  coreTracePkg::stuckCntT stuckLimit,
  input  coreTracePkg::pcT       passFailAddr [coreTracePkg::PassFailEntries],
  output coreTracePkg::verdictT  verdict,
  output logic                   stuck
);
  import coreTracePkg::*;

  pcT       lastPc;    // Last valid PC seen
  stuckCntT stuckCnt;
  logic     judging;
  logic     passHit;
  logic     failHit;
  logic     stuckHit;

  assign judging = curPcValid && !coreReset;

  // ------------------------------
  // Address match by entry role
  // ------------------------------
  always_comb begin
    passHit = 1'b0;
    failHit = 1'b0;
    if (judging) begin
      if (!tableValid) begin
        failHit = 1'b1;  // Table never loaded
      end else if ((curPc == passFailAddr[EntryTestPass]) ||
                   (curPc == passFailAddr[EntryFinish]) ||
                   (checkToHost && (curPc == passFailAddr[EntryToHost]))) begin
        passHit = 1'b1;
      end else if ((curPc == passFailAddr[EntryTestFail]) ||
                   (curPc == passFailAddr[EntryHang])) begin
        failHit = 1'b1;
      end
    end
  end

  assign stuckHit = (stuckCnt >= stuckLimit) && !disableStuck && !coreReset;

  // Repeat counter, frozen once a verdict is in
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      lastPc   <= '0;
      stuckCnt <= '0;
    end else if (curPcValid) begin
      lastPc <= curPc;
      if (verdict == verdictNone) begin
        if (curPc == lastPc) begin
          stuckCnt <= stuckCnt + 1'b1;
        end else begin
          stuckCnt <= '0;
        end
      end
    end
  end

  // ------------------------------
  // Sticky verdict
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      verdict <= verdictNone;
      stuck   <= 1'b0;
    end else if (forceFailPulse) begin
      verdict <= verdictFail;  // Overrides an earlier pass
    end else if (verdict == verdictNone) begin
      if (stuckHit) begin
        verdict <= verdictFail;
        stuck   <= 1'b1;
      end else if (passHit) begin
        verdict <= verdictPass;
      end else if (failHit) begin
        verdict <= verdictFail;
      end
    end
  end

endmodule
